// File: verilog/cvwConfigPkg.sv
// Defaults for the standard core; XLEN is 32 or 64 and the queue depth must be at least 4
package cvwConfigPkg;

  // register width
  parameter int DEFAULT_XLEN        = 32;

  // raw instruction entries between aligner and decode
  parameter int DEFAULT_QUEUE_DEPTH = 8;

  // compressed extension subsets
  parameter bit DEFAULT_ZCB   = 1'b1;
  parameter bit DEFAULT_ZCD   = 1'b0; // no double FP registers
  parameter bit DEFAULT_ZCF   = 1'b0; // no single FP registers

  // extensions that some Zcb forms depend on
  parameter bit DEFAULT_ZBB   = 1'b1;
  parameter bit DEFAULT_ZBA   = 1'b1;
  parameter bit DEFAULT_ZMMUL = 1'b1;

endpackage

// File: verilog/rvInstrPkg.sv
// Instruction level types shared by fetch and decode; PCs are 32 bits even on RV64
package rvInstrPkg;

  // major opcodes, bits 6:0 of a 32-bit instruction
  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,
    opLoadFp  = 7'b0000111,
    opOpImm   = 7'b0010011,
    opOpImm32 = 7'b0011011,
    opStore   = 7'b0100011,
    opStoreFp = 7'b0100111,
    opOp      = 7'b0110011,
    opOp32    = 7'b0111011,
    opLui     = 7'b0110111,
    opBranch  = 7'b1100011,
    opJalr    = 7'b1100111,
    opJal     = 7'b1101111,
    opSystem  = 7'b1110011
  } opcodeT;

  typedef struct packed {
    logic [31:0] raw; // compressed forms sit in the low half
    logic [31:0] pc;
  } queueEntryT;

  typedef struct packed {
    logic [31:0] instr; // expanded 32-bit form
    logic [31:0] pc;
    logic        illegal;
    logic        compressed;
  } decodedT;

endpackage

// File: verilog/parcelAligner.sv
// Fetch words must be sequential and word aligned from PC 0; no redirect or flush support
`timescale 1ns/1ps

module parcelAligner (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [31:0]            fetchWord,
  input  logic                   fetchValid,
  output logic                   stall,
  output rvInstrPkg::queueEntryT entry,
  output logic                   push,
  input  logic                   almostFull
);

  typedef enum logic [1:0] {alignEmpty, alignHalf, alignFull} alignStateT;

  alignStateT       state, stateNext;
  logic [2:0][15:0] parcels;   // oldest halfword in slot 0
  logic [2:0][15:0] view, viewShift;
  logic [1:0]       parcelCnt, availCnt, remainCnt, shiftBy;
  logic [31:0]      pc;
  logic             accept, isComp, complete, emit;

  // a whole instruction already waiting blocks the next word
  assign stall  = (state == alignFull);
  assign accept = fetchValid && !stall && !almostFull;

  //////////////////////////////////////////////////
  // parcels visible this cycle, buffer then new word
  always_comb begin
    view     = parcels;
    availCnt = parcelCnt;
    if (accept) begin
      if (parcelCnt == 2'd0) begin
        view[0] = fetchWord[15:0];
        view[1] = fetchWord[31:16];
      end else begin
        view[1] = fetchWord[15:0]; // completes a 32-bit low half
        view[2] = fetchWord[31:16];
      end
      availCnt = parcelCnt + 2'd2;
    end
  end

  assign isComp   = (view[0][1:0] != 2'b11);
  assign complete = (availCnt != 2'd0) && (isComp || availCnt >= 2'd2);
  assign emit     = complete && !almostFull; // queue has no room to spare
  assign shiftBy  = emit ? (isComp ? 2'd1 : 2'd2) : 2'd0;

  assign viewShift = view >> (16 * shiftBy);
  assign remainCnt = availCnt - shiftBy;

  always_comb begin
    if (remainCnt == 2'd0) stateNext = alignEmpty;
    else if (remainCnt == 2'd1 && viewShift[0][1:0] == 2'b11) stateNext = alignHalf;
    else stateNext = alignFull;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= alignEmpty;
      parcelCnt <= 2'd0;
      pc        <= 32'd0;
      push      <= 1'b0;
    end else begin
      state     <= stateNext;
      parcelCnt <= remainCnt;
      push      <= emit;
      if (emit) pc <= pc + (isComp ? 32'd2 : 32'd4);
    end
  end

  always_ff @(posedge clk) begin
    parcels <= viewShift;
    if (emit) begin
      entry.raw <= isComp ? {16'h0000, view[0]} : {view[1], view[0]};
      entry.pc  <= pc;
    end
  end

endmodule

// File: verilog/instrQueue.sv
// queueDepth must be at least 4; almostFull leaves room for the one entry still in flight
`timescale 1ns/1ps

module instrQueue #(
  parameter int queueDepth = 8
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  rvInstrPkg::queueEntryT entry,
  input  logic                   push,
  input  logic                   pop,
  output rvInstrPkg::queueEntryT head,
  output logic                   empty,
  output logic                   almostFull
);
  import rvInstrPkg::*;

  localparam int ptrW = $clog2(queueDepth);
  localparam int cntW = $clog2(queueDepth + 1);

  queueEntryT      mem [queueDepth];
  logic [ptrW-1:0] wrPtr, rdPtr;
  logic [cntW-1:0] count;
  logic            doPop;

  assign empty      = (count == '0);
  assign almostFull = (count >= cntW'(queueDepth - 2));
  assign head       = mem[rdPtr];

  assign doPop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      if (push && !doPop) count <= count + 1'b1;
      else if (doPop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= entry;
  end

endmodule

// File: verilog/decompress.sv
// RV32/RV64 C and Zcb only; RV128 forms and the reserved-immediate checks are not decoded
`timescale 1ns/1ps

module decompress #(
  parameter int xlen           = 32,
  parameter bit zcbSupported   = 1'b1,
  parameter bit zcdSupported   = 1'b0,
  parameter bit zcfSupported   = 1'b0,
  parameter bit zbbSupported   = 1'b1,
  parameter bit zbaSupported   = 1'b1,
  parameter bit zmmulSupported = 1'b1
) (
  input  logic [31:0] instrRaw,
  output logic [31:0] instr,
  output logic        illegalComp
);
  import rvInstrPkg::*;

  localparam bit          rv64     = (xlen > 32);
  localparam logic [31:0] nopInstr = {25'b0, opOpImm}; // addi x0, x0, 0

  logic [15:0] c;
  logic [4:0]  sel, rd, rs2, rs1c, rs2c;
  logic [11:0] imm4spn, immW, immD, lwSp, ldSp, swSp, sdSp, immCi, imm16sp;
  logic [19:0] immJ, immLui;
  logic [6:0]  brHi;
  logic [4:0]  brLo;
  logic [5:0]  shamt;
  logic [32:0] res, alu; // bit 32 set when legal

  assign c    = instrRaw[15:0];
  assign sel  = {c[1:0], c[15:13]}; // quadrant and funct3
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  assign rs1c = {2'b01, c[9:7]}; // x8 to x15
  assign rs2c = {2'b01, c[4:2]};

  //////////////////////////////////////////////////
  // immediates per compressed format
  assign imm4spn = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
  assign immW    = {5'b0, c[5], c[12:10], c[6], 2'b00};
  assign immD    = {4'b0, c[6:5], c[12:10], 3'b000};
  assign lwSp    = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
  assign ldSp    = {3'b0, c[4:2], c[12], c[6:5], 3'b000};
  assign swSp    = {4'b0, c[8:7], c[12:9], 2'b00};
  assign sdSp    = {3'b0, c[9:7], c[12:10], 3'b000};
  assign immCi   = {{7{c[12]}}, c[6:2]};
  assign imm16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
  assign immLui  = {{15{c[12]}}, c[6:2]};
  assign immJ    = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}}};
  assign brHi    = {{4{c[12]}}, c[6:5], c[2]};
  assign brLo    = {c[11:10], c[4:3], c[12]};
  assign shamt   = {c[12], c[6:2]};

  // quadrant 1 register forms with bits 11:10 set
  always_comb begin
    alu = {1'b0, 16'h0000, c};
    case ({c[12], c[6:5]})
      3'b000: alu = {1'b1, 7'b0100000, rs2c, rs1c, 3'b000, rs1c, opOp}; // c.sub
      3'b001: alu = {1'b1, 7'b0000000, rs2c, rs1c, 3'b100, rs1c, opOp}; // c.xor
      3'b010: alu = {1'b1, 7'b0000000, rs2c, rs1c, 3'b110, rs1c, opOp}; // c.or
      3'b011: alu = {1'b1, 7'b0000000, rs2c, rs1c, 3'b111, rs1c, opOp}; // c.and
      3'b100: if (rv64) alu = {1'b1, 7'b0100000, rs2c, rs1c, 3'b000, rs1c, opOp32}; // c.subw
      3'b101: if (rv64) alu = {1'b1, 7'b0000000, rs2c, rs1c, 3'b000, rs1c, opOp32}; // c.addw
      3'b110: // c.mul
        if (zcbSupported && zmmulSupported)
          alu = {1'b1, 7'b0000001, rs2c, rs1c, 3'b000, rs1c, opOp};
      default: if (zcbSupported) begin // Zcb unary ops
        case (c[4:2])
          3'b000: alu = {1'b1, 12'h0ff, rs1c, 3'b111, rs1c, opOpImm}; // c.zext.b
          3'b001: if (zbbSupported) alu = {1'b1, 12'h604, rs1c, 3'b001, rs1c, opOpImm}; // c.sext.b
          3'b010: if (zbbSupported) alu = {1'b1, 12'h080, rs1c, 3'b100, rs1c, rv64 ? opOp32 : opOp};
          3'b011: if (zbbSupported) alu = {1'b1, 12'h605, rs1c, 3'b001, rs1c, opOpImm}; // c.sext.h
          3'b100: if (zbaSupported && rv64) alu = {1'b1, 12'h080, rs1c, 3'b000, rs1c, opOp32};
          3'b101: alu = {1'b1, 12'hfff, rs1c, 3'b100, rs1c, opOpImm}; // c.not
          default: ;
        endcase
      end
    endcase
  end

  always_comb begin
    res = {1'b0, 16'h0000, c}; // raw halfword unless an encoding below matches
    if (c[1:0] == 2'b11) begin
      res = {1'b1, instrRaw};
    end else begin
      case (sel)
        5'b00000: // c.addi4spn
          if (imm4spn != '0) res = {1'b1, imm4spn, 5'd2, 3'b000, rs2c, opOpImm};
        5'b00001: if (zcdSupported) res = {1'b1, immD, rs1c, 3'b011, rs2c, opLoadFp}; // c.fld
        5'b00010: res = {1'b1, immW, rs1c, 3'b010, rs2c, opLoad}; // c.lw
        5'b00011: // c.ld on rv64, c.flw on rv32
          if (rv64) res = {1'b1, immD, rs1c, 3'b011, rs2c, opLoad};
          else if (zcfSupported) res = {1'b1, immW, rs1c, 3'b010, rs2c, opLoadFp};
        5'b00100: if (zcbSupported) begin // byte and half loads, stores
          case (c[12:10])
            3'b000: res = {1'b1, 10'b0, c[5], c[6], rs1c, 3'b100, rs2c, opLoad}; // c.lbu
            3'b001: res = {1'b1, 10'b0, c[5], 1'b0, rs1c, c[6] ? 3'b001 : 3'b101, rs2c, opLoad};
            3'b010: res = {1'b1, 7'b0, rs2c, rs1c, 3'b000, 3'b000, c[5], c[6], opStore}; // c.sb
            3'b011: if (!c[6]) res = {1'b1, 7'b0, rs2c, rs1c, 3'b001, 3'b000, c[5], 1'b0, opStore};
            default: ;
          endcase
        end
        5'b00101: // c.fsd
          if (zcdSupported) res = {1'b1, immD[11:5], rs2c, rs1c, 3'b011, immD[4:0], opStoreFp};
        5'b00110: res = {1'b1, immW[11:5], rs2c, rs1c, 3'b010, immW[4:0], opStore}; // c.sw
        5'b00111: // c.sd on rv64, c.fsw on rv32
          if (rv64) res = {1'b1, immD[11:5], rs2c, rs1c, 3'b011, immD[4:0], opStore};
          else if (zcfSupported)
            res = {1'b1, immW[11:5], rs2c, rs1c, 3'b010, immW[4:0], opStoreFp};
        5'b01000: // c.addi, zero forms are hints
          if (rd != 5'd0 && immCi[5:0] != 6'd0) res = {1'b1, immCi, rd, 3'b000, rd, opOpImm};
          else res = {1'b1, nopInstr};
        5'b01001: // c.jal on rv32, c.addiw on rv64
          if (!rv64) res = {1'b1, immJ, 5'd1, opJal};
          else if (rd != 5'd0) res = {1'b1, immCi, rd, 3'b000, rd, opOpImm32};
        5'b01010: // c.li
          if (rd != 5'd0) res = {1'b1, immCi, 5'd0, 3'b000, rd, opOpImm};
          else res = {1'b1, nopInstr};
        5'b01011: // c.addi16sp, c.lui
          if (rd == 5'd2) res = {1'b1, imm16sp, rd, 3'b000, rd, opOpImm};
          else if (rd != 5'd0) res = {1'b1, immLui, rd, opLui};
          else if (immLui[5:0] != 6'd0) res = {1'b1, nopInstr};
        5'b01100:
          case (c[11:10])
            2'b00: // c.srli
              if (rv64 || !shamt[5]) res = {1'b1, 6'b000000, shamt, rs1c, 3'b101, rs1c, opOpImm};
            2'b01: // c.srai
              if (rv64 || !shamt[5]) res = {1'b1, 6'b010000, shamt, rs1c, 3'b101, rs1c, opOpImm};
            2'b10: res = {1'b1, immCi, rs1c, 3'b111, rs1c, opOpImm}; // c.andi
            default: res = alu;
          endcase
        5'b01101: res = {1'b1, immJ, 5'd0, opJal}; // c.j
        5'b01110: res = {1'b1, brHi, 5'd0, rs1c, 3'b000, brLo, opBranch}; // c.beqz
        5'b01111: res = {1'b1, brHi, 5'd0, rs1c, 3'b001, brLo, opBranch}; // c.bnez
        5'b10000: // c.slli
          if (rd == 5'd0) res = {1'b1, nopInstr};
          else if (rv64 || !shamt[5]) res = {1'b1, 6'b0, shamt, rd, 3'b001, rd, opOpImm};
        5'b10001: if (zcdSupported) res = {1'b1, ldSp, 5'd2, 3'b011, rd, opLoadFp}; // c.fldsp
        5'b10010: if (rd != 5'd0) res = {1'b1, lwSp, 5'd2, 3'b010, rd, opLoad}; // c.lwsp
        5'b10011: // c.ldsp on rv64, c.flwsp on rv32
          if (rv64) begin
            if (rd != 5'd0) res = {1'b1, ldSp, 5'd2, 3'b011, rd, opLoad};
          end else if (zcfSupported) res = {1'b1, lwSp, 5'd2, 3'b010, rd, opLoadFp};
        5'b10100: // c.jr, c.mv, c.ebreak, c.jalr, c.add
          if (rs2 != 5'd0) begin
            if (rd == 5'd0) res = {1'b1, nopInstr};
            else res = {1'b1, 7'b0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, opOp};
          end else if (rd != 5'd0) res = {1'b1, 12'd0, rd, 3'b000, 4'd0, c[12], opJalr};
          else if (c[12]) res = {1'b1, 12'd1, 13'd0, opSystem};
        5'b10101: // c.fsdsp
          if (zcdSupported) res = {1'b1, sdSp[11:5], rs2, 5'd2, 3'b011, sdSp[4:0], opStoreFp};
        5'b10110: res = {1'b1, swSp[11:5], rs2, 5'd2, 3'b010, swSp[4:0], opStore}; // c.swsp
        5'b10111: // c.sdsp on rv64, c.fswsp on rv32
          if (rv64) res = {1'b1, sdSp[11:5], rs2, 5'd2, 3'b011, sdSp[4:0], opStore};
          else if (zcfSupported)
            res = {1'b1, swSp[11:5], rs2, 5'd2, 3'b010, swSp[4:0], opStoreFp};
        default: ;
      endcase
    end
  end

  assign instr       = res[31:0];
  assign illegalComp = ~res[32];

endmodule

// File: verilog/decodeStage.sv
// One instruction per cycle; a result held by decodeStall is presented again once it drops
`timescale 1ns/1ps

module decodeStage #(
  parameter int xlen           = 32,
  parameter bit zcbSupported   = 1'b1,
  parameter bit zcdSupported   = 1'b0,
  parameter bit zcfSupported   = 1'b0,
  parameter bit zbbSupported   = 1'b1,
  parameter bit zbaSupported   = 1'b1,
  parameter bit zmmulSupported = 1'b1
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  rvInstrPkg::queueEntryT head,
  input  logic                   empty,
  input  logic                   decodeStall,
  output logic                   pop,
  output rvInstrPkg::decodedT    decoded,
  output logic                   decodedValid
);

  logic [31:0] expanded;
  logic        illegal;
  logic        validQ; // output register holds a result

  decompress #(
    .xlen(xlen), .zcbSupported(zcbSupported), .zcdSupported(zcdSupported),
    .zcfSupported(zcfSupported), .zbbSupported(zbbSupported),
    .zbaSupported(zbaSupported), .zmmulSupported(zmmulSupported)
  ) decompress_i (
    .instrRaw(head.raw),
    .instr(expanded),
    .illegalComp(illegal)
  );

  assign pop          = !empty && !decodeStall;
  assign decodedValid = validQ && !decodeStall;

  always_ff @(posedge clk) begin
    if (!rstN) validQ <= 1'b0;
    else if (!decodeStall) validQ <= !empty; // frozen while stalled
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      decoded.instr      <= expanded;
      decoded.pc         <= head.pc;
      decoded.illegal    <= illegal;
      decoded.compressed <= (head.raw[1:0] != 2'b11);
    end
  end

endmodule

// File: verilog/compressedFetch.sv
// No branch redirect; fetch starts word aligned at PC 0 and fetchValid holds while fetchStall is high
`timescale 1ns/1ps

module compressedFetch #(
  parameter int xlen           = cvwConfigPkg::DEFAULT_XLEN,
  parameter int queueDepth     = cvwConfigPkg::DEFAULT_QUEUE_DEPTH,
  parameter bit zcbSupported   = cvwConfigPkg::DEFAULT_ZCB,
  parameter bit zcdSupported   = cvwConfigPkg::DEFAULT_ZCD,
  parameter bit zcfSupported   = cvwConfigPkg::DEFAULT_ZCF,
  parameter bit zbbSupported   = cvwConfigPkg::DEFAULT_ZBB,
  parameter bit zbaSupported   = cvwConfigPkg::DEFAULT_ZBA,
  parameter bit zmmulSupported = cvwConfigPkg::DEFAULT_ZMMUL
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic [31:0]         fetchWord,
  input  logic                fetchValid,
  input  logic                decodeStall,
  output logic                fetchStall,
  output rvInstrPkg::decodedT decoded,
  output logic                decodedValid
);
  import rvInstrPkg::*;

  queueEntryT entry, head;
  logic       alignStall, push, pop, empty, almostFull;

  assign fetchStall = alignStall || almostFull; // aligner busy or queue nearly full

  parcelAligner parcelAligner_i (
    .clk, .rstN, .fetchWord, .fetchValid, .stall(alignStall),
    .entry, .push, .almostFull
  );

  instrQueue #(.queueDepth(queueDepth)) instrQueue_i (
    .clk, .rstN, .entry, .push, .pop, .head, .empty, .almostFull
  );

  decodeStage #(
    .xlen(xlen), .zcbSupported(zcbSupported), .zcdSupported(zcdSupported),
    .zcfSupported(zcfSupported), .zbbSupported(zbbSupported),
    .zbaSupported(zbaSupported), .zmmulSupported(zmmulSupported)
  ) decodeStage_i (
    .clk, .rstN, .head, .empty, .decodeStall, .pop, .decoded, .decodedValid
  );

endmodule

// File: sim/tbChecker.sv
// Compares decoded results strictly in order; expected entries must be loaded before decode starts
`timescale 1ns/1ps

module tbChecker (
  input logic                clk,
  input logic                rstN,
  input logic                decodeStall,
  input logic                fetchStall,
  input rvInstrPkg::decodedT decoded,
  input logic                decodedValid
);
  import rvInstrPkg::*;

  decodedT expectQ [$];
  int      seenCount  = 0;
  int      errorCount = 0;
  logic    prevRstN   = 1'b0; // rstN one cycle back

  function automatic string opName(input logic [31:0] instr);
    opcodeT op;
    op = opcodeT'(instr[6:0]);
    return (op.name() == "") ? "unknown-op" : op.name();
  endfunction

  task automatic addExpected(input decodedT e);
    expectQ.push_back(e);
  endtask

  task automatic finalCheck(input int total);
    if (expectQ.size() != 0) begin
      $display("missing outputs: %0d of %0d instructions never left decode",
               expectQ.size(), total);
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // aligner and queue both come out of reset idle
  always @(posedge clk) begin
    if (rstN && !prevRstN && fetchStall !== 1'b0) begin
      $display("[ERROR] %0t: fetchStall %b in the first cycle after reset", $time, fetchStall);
      errorCount++;
    end
    prevRstN <= rstN;
  end

  always @(posedge clk) begin
    decodedT exp;
    if ((!rstN || decodeStall) && decodedValid) begin
      $display("[ERROR] %0t: decodedValid high %s", $time,
               rstN ? "while decodeStall is high" : "during reset");
      errorCount++;
    end else if (decodedValid) begin
      if (expectQ.size() == 0) begin
        $display("unexpected output: instruction %h at pc %h after all expected results",
                 decoded.instr, decoded.pc);
        errorCount++;
      end else begin
        exp = expectQ.pop_front();
        seenCount++;
        if (decoded !== exp) begin // whole struct, pc and flags included
          $display("[ERROR] %0t: %s pc %h: got %h ill %b c %b, expected pc %h %h ill %b c %b",
                   $time, opName(exp.instr), decoded.pc, decoded.instr, decoded.illegal,
                   decoded.compressed, exp.pc, exp.instr, exp.illegal, exp.compressed);
          errorCount++;
        end
      end
    end
  end

endmodule

// File: sim/instrQueue_asserts.sv
// Bound into every instrQueue; all checks are off while rstN is low
`timescale 1ns/1ps

module instrQueue_asserts #(
  parameter int queueDepth = 8
) (
  input logic                              clk,
  input logic                              rstN,
  input logic                              push,
  input logic                              pop,
  input logic                              empty,
  input logic                              almostFull,
  input logic [$clog2(queueDepth + 1)-1:0] count
);
  localparam int cntW = $clog2(queueDepth + 1);

  int failCount = 0; // failed assertions so far

  noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
    !(push && count == cntW'(queueDepth))) else begin
    failCount++;
    $error("push into a full queue");
  end

  noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
    !(pop && empty)) else begin
    failCount++;
    $error("pop from an empty queue");
  end

  almostFullKnown: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown(almostFull)) else begin
    failCount++;
    $error("almostFull is unknown");
  end

  countInRange: assert property (@(posedge clk) disable iff (!rstN)
    count <= cntW'(queueDepth)) else begin
    failCount++;
    $error("queue count above its depth");
  end

endmodule

bind instrQueue instrQueue_asserts #(.queueDepth(queueDepth)) instrQueueAsserts_i (
  .clk, .rstN, .push, .pop, .empty, .almostFull, .count
);

// File: sim/compressedFetchTb.sv
// Stimulus must fill whole fetch words (even halfword count); run from the project root
`timescale 1ns/1ps

module compressedFetchTb;
  import rvInstrPkg::*;

  localparam string stimFile = "sim/decompressStimulus.txt";

  logic        clk;
  logic        rstN;
  logic [31:0] fetchWord;
  logic        fetchValid;
  logic        decodeStall;
  logic        fetchStall;
  logic        decodedValid;
  decodedT     decoded;

  logic [15:0] halves [$]; // instruction stream, oldest first
  int          numInstr     = 0;
  int          cycleCount   = 0;
  int          timeoutLimit = 0;

  compressedFetch compressedFetch_i (
    .clk, .rstN, .fetchWord, .fetchValid, .decodeStall,
    .fetchStall, .decoded, .decodedValid
  );

  tbChecker tbChecker_i (.clk, .rstN, .decodeStall, .fetchStall, .decoded, .decodedValid);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus file to halfword stream and expected results
  task automatic loadStimulus(output bit opened);
    int          fd;
    int          n;
    string       line;
    string       rawText;
    logic [31:0] raw, expInstr, illegalBit, pc;
    bit          isComp;
    decodedT     exp;
    pc     = 32'd0;
    opened = 1'b0;
    fd = $fopen(stimFile, "r");
    if (fd != 0) begin
      opened = 1'b1;
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%s %h %h", rawText, expInstr, illegalBit) == 3 &&
            (rawText.len() == 4 || rawText.len() == 8)) begin
          isComp = (rawText.len() == 4); // four hex digits for a halfword
          raw    = rawText.atohex();
          exp.instr      = expInstr;
          exp.pc         = pc;
          exp.illegal    = illegalBit[0];
          exp.compressed = isComp;
          tbChecker_i.addExpected(exp);
          halves.push_back(raw[15:0]);
          if (!isComp) begin
            halves.push_back(raw[31:16]);
            pc = pc + 32'd4;
          end else begin
            pc = pc + 32'd2;
          end
          numInstr++;
        end
      end
      $fclose(fd);
    end
  endtask

  // holds the word until the fetch side takes it
  task automatic sendWord(input logic [31:0] word);
    fetchWord  = word;
    fetchValid = 1'b1;
    while (fetchStall) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk); // accepted on this edge
    #1;
  endtask

  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'ha8f31889));
    forever begin
      @(posedge clk);
      #1;
      if (rstN) decodeStall = ($urandom % 3) == 0; // stall about a third of cycles
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
      $display("timeout after %0d cycles, %0d of %0d instructions decoded",
               cycleCount, tbChecker_i.seenCount, numInstr);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    bit opened;
    int totalErrors;
    rstN        = 1'b0;
    fetchWord   = 32'd0;
    fetchValid  = 1'b0;
    decodeStall = 1'b0;
    loadStimulus(opened);
    if (!opened || numInstr == 0) begin
      $display("no stimulus could be read from %s", stimFile);
      $display("tests failed");
      $finish;
    end else begin
      timeoutLimit = 20 * numInstr + 50;
      repeat (2) @(posedge clk);
      #1;
      rstN = 1'b1;
      for (int i = 0; i + 1 < halves.size(); i += 2) begin
        sendWord({halves[i+1], halves[i]}); // first halfword in the low half
      end
      fetchValid = 1'b0;
      while (tbChecker_i.seenCount < numInstr) @(posedge clk);
      repeat (10) @(posedge clk); // catch any extra outputs
      tbChecker_i.finalCheck(numInstr);
      totalErrors = tbChecker_i.errorCount
                    + compressedFetch_i.instrQueue_i.instrQueueAsserts_i.failCount;
      $display("closing report: %0d of %0d instructions checked, %0d errors, %0d in assertions",
               tbChecker_i.seenCount, numInstr, totalErrors,
               compressedFetch_i.instrQueue_i.instrQueueAsserts_i.failCount);
      if (totalErrors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

// File: compressedFetch.f
verilog/cvwConfigPkg.sv
verilog/rvInstrPkg.sv
verilog/parcelAligner.sv
verilog/instrQueue.sv
verilog/decompress.sv
verilog/decodeStage.sv
verilog/compressedFetch.sv
sim/tbChecker.sv
sim/instrQueue_asserts.sv
sim/compressedFetchTb.sv

// File: Makefile
# Verilator build and run of the compressed fetch testbench
VERILATOR ?= verilator
TOP       ?= compressedFetchTb
FILELIST  ?= compressedFetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR FILELIST OBJ_DIR LOG SEED"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
	  echo "FAIL: see $(LOG)"; exit 1; \
	else \
	  echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/decompressStimulus.txt
// raw instruction (4 hex digits compressed, 8 hex digits 32-bit)  expected expansion  illegal
// default config: RV32, Zcb, Zbb, Zba, Zmmul on; Zcd, Zcf off
00500093  00500093  0  // addi x1, x0, 5
0800      01010413  0  // c.addi4spn x8, sp, 16
002081B3  002081B3  0  // add x3, x1, x2 across a word boundary
4144      00452483  0  // c.lw x9, 4(x10)
C60C      00B62423  0  // c.sw x11, 8(x12)
12F5      FFD28293  0  // c.addi x5, -3
451D      00700513  0  // c.li x10, 7
6785      000017B7  0  // c.lui x15, 1
6105      02010113  0  // c.addi16sp 32
123452B7  123452B7  0  // lui x5, 0x12345 across a word boundary
800D      00345413  0  // c.srli x8, 3
8C89      40A484B3  0  // c.sub x9, x10
0000      00000000  1  // all zero is illegal
A021      0080006F  0  // c.j +8
FCF5      FE049EE3  0  // c.bnez x9, -4
0512      00451513  0  // c.slli x10, 4
96BA      00E686B3  0  // c.add x13, x14
9C61      0FF47413  0  // c.zext.b x8
9C45      02940433  0  // c.mul x8, x9
0015      00000013  0  // c.addi x0 hint becomes nop
2000      00002000  1  // c.fld without Zcd
403100B3  403100B3  0  // sub x1, x2, x3
